//--- hw/hiLoPkg.sv
`default_nettype none

package hiLoPkg;

	// datapath widths
	localparam int WORD_WIDTH = 32;
	// one result bit per step
	localparam int STEP_COUNT = WORD_WIDTH;

	typedef logic [WORD_WIDTH-1:0] word_t;
	// product, or remainder and quotient side by side
	typedef logic [2*WORD_WIDTH-1:0] dword_t;
	typedef logic [$clog2(STEP_COUNT+1)-1:0] stepCount_t;

	// multiply/divide opcodes as decoded for the HI/LO unit
	typedef enum logic [1:0] {
		OP_MULT  = 2'b00,
		OP_MULTU = 2'b01,
		OP_DIV   = 2'b10,
		OP_DIVU  = 2'b11
	} mulDivOp_t;

	// register select for reads and direct moves
	typedef enum logic {
		SEL_LO = 1'b0,
		SEL_HI = 1'b1
	} hiLoSel_t;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'b00,
		ST_RUN    = 2'b01,
		ST_COMMIT = 2'b10
	} mulDivState_t;

endpackage

`default_nettype wire

//--- hw/mulDivCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module mulDivCtrl import hiLoPkg::*; (
	input  wire logic      clk,
	input  wire logic      rstN,
	input  wire logic      start,
	input  wire mulDivOp_t op,
	input  wire logic      flush,
	input  wire logic      hiLoWr,
	input  wire logic      lastStep,
	output logic           load,
	output logic           step,
	output logic           commit,
	output logic           resultIsDiv,
	output logic           moveWr,
	output logic           busy
);

	mulDivState_t state;
	mulDivState_t nextState;

	always_comb begin
		nextState = state;
		unique case (state)
			ST_IDLE: begin
				if (start) nextState = ST_RUN;
			end
			ST_RUN: begin
				if (flush) nextState = ST_IDLE;
				else if (lastStep) nextState = ST_COMMIT;
			end
			ST_COMMIT: begin
				nextState = ST_IDLE;
			end
			default: begin
				nextState = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state       <= ST_IDLE;
			resultIsDiv <= 1'b0;
		end else begin
			state <= nextState;
			if (load) resultIsDiv <= (op == OP_DIV) || (op == OP_DIVU);
		end
	end

	// start and moves only count while idle
	assign load   = start && (state == ST_IDLE);
	assign moveWr = hiLoWr && (state == ST_IDLE);
	assign step   = (state == ST_RUN);
	// a late flush still cancels the write
	assign commit = (state == ST_COMMIT) && !flush;
	assign busy   = (state != ST_IDLE);

	// an unflushed operation commits right after its last step
	assert property (@(posedge clk) disable iff (!rstN || flush)
		load |-> ##(STEP_COUNT + 1) commit);

endmodule

`default_nettype wire

//--- hw/stepCounter.sv
`timescale 1ns/100ps
`default_nettype none

module stepCounter import hiLoPkg::*; (
	input  wire logic clk,
	input  wire logic rstN,
	input  wire logic load,
	input  wire logic step,
	output logic      lastStep
);

	stepCount_t count;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (load) begin
			count <= stepCount_t'(STEP_COUNT);
		end else if (step) begin
			count <= count - stepCount_t'(1);
		end
	end

	// true during the final step cycle
	assign lastStep = (count == stepCount_t'(1));

	// the controller must leave RUN before the count runs out
	assert property (@(posedge clk) disable iff (!rstN)
		step |-> (count != '0));

endmodule

`default_nettype wire

//--- hw/seqMultiplier.sv
`timescale 1ns/100ps
`default_nettype none

module seqMultiplier import hiLoPkg::*; (
	input  wire logic      clk,
	input  wire logic      rstN,
	input  wire logic      load,
	input  wire logic      step,
	input  wire mulDivOp_t op,
	input  wire word_t     a,
	input  wire word_t     b,
	output dword_t         product
);

	logic   isSigned;
	word_t  magA;
	word_t  magB;
	dword_t mcand;
	word_t  mplier;
	dword_t acc;
	logic   negProd;

	assign isSigned = (op == OP_MULT);
	// magnitudes; the most negative value maps onto itself as unsigned
	assign magA = (isSigned && a[WORD_WIDTH-1]) ? -a : a;
	assign magB = (isSigned && b[WORD_WIDTH-1]) ? -b : b;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			acc     <= '0;
			negProd <= 1'b0;
		end else if (load) begin
			acc     <= '0;
			negProd <= isSigned && (a[WORD_WIDTH-1] ^ b[WORD_WIDTH-1]);
		end else if (step && mplier[0]) begin
			acc <= acc + mcand;
		end
	end

	// operand shifters
	always_ff @(posedge clk) begin
		if (load) begin
			mcand  <= {{WORD_WIDTH{1'b0}}, magA};
			mplier <= magB;
		end else if (step) begin
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign product = negProd ? -acc : acc;

endmodule

`default_nettype wire

//--- hw/iterDivider.sv
`timescale 1ns/100ps
`default_nettype none

module iterDivider import hiLoPkg::*; (
	input  wire logic      clk,
	input  wire logic      rstN,
	input  wire logic      load,
	input  wire logic      step,
	input  wire mulDivOp_t op,
	input  wire word_t     a,
	input  wire word_t     b,
	output word_t          quotient,
	output word_t          remainder
);

	logic                isSigned;
	word_t               magA;
	word_t               magB;
	word_t               remReg;
	word_t               quoReg;
	word_t               divisor;
	logic                negQuo;
	logic                negRem;
	logic [WORD_WIDTH:0] shifted;
	logic [WORD_WIDTH:0] diff;
	logic                fits;

	assign isSigned = (op == OP_DIV);
	assign magA = (isSigned && a[WORD_WIDTH-1]) ? -a : a;
	assign magB = (isSigned && b[WORD_WIDTH-1]) ? -b : b;

	// next dividend bit enters the partial remainder
	assign shifted = {remReg, quoReg[WORD_WIDTH-1]};
	assign diff    = shifted - {1'b0, divisor};
	assign fits    = (shifted >= {1'b0, divisor});

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			negQuo <= 1'b0;
			negRem <= 1'b0;
		end else if (load) begin
			negQuo <= isSigned && (a[WORD_WIDTH-1] ^ b[WORD_WIDTH-1]);
			// remainder follows the dividend
			negRem <= isSigned && a[WORD_WIDTH-1];
		end
	end

	// quoReg starts as the dividend and fills with quotient bits from the right
	always_ff @(posedge clk) begin
		if (load) begin
			remReg  <= '0;
			quoReg  <= magA;
			divisor <= magB;
		end else if (step) begin
			if (fits) begin
				remReg <= diff[WORD_WIDTH-1:0];
				quoReg <= {quoReg[WORD_WIDTH-2:0], 1'b1};
			end else begin
				// restore, keep the shifted value
				remReg <= shifted[WORD_WIDTH-1:0];
				quoReg <= {quoReg[WORD_WIDTH-2:0], 1'b0};
			end
		end
	end

	// sign fix on magnitudes gives truncation toward zero
	assign quotient  = negQuo ? -quoReg : quoReg;
	assign remainder = negRem ? -remReg : remReg;

endmodule

`default_nettype wire

//--- hw/hiLoRegs.sv
`timescale 1ns/100ps
`default_nettype none

module hiLoRegs import hiLoPkg::*; (
	input  wire logic     clk,
	input  wire logic     rstN,
	input  wire logic     commit,
	input  wire logic     resultIsDiv,
	input  wire dword_t   product,
	input  wire word_t    quotient,
	input  wire word_t    remainder,
	input  wire logic     moveWr,
	input  wire hiLoSel_t hiLoSelWr,
	input  wire word_t    moveData,
	input  wire hiLoSel_t hiLoSelRd,
	output word_t         hiLoOut
);

	word_t hi;
	word_t lo;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hi <= '0;
			lo <= '0;
		end else if (commit) begin
			if (resultIsDiv) begin
				hi <= remainder;
				lo <= quotient;
			end else begin
				hi <= product[2*WORD_WIDTH-1:WORD_WIDTH];
				lo <= product[WORD_WIDTH-1:0];
			end
		end else if (moveWr) begin
			// MTHI / MTLO
			if (hiLoSelWr == SEL_HI) hi <= moveData;
			else lo <= moveData;
		end
	end

	assign hiLoOut = (hiLoSelRd == SEL_HI) ? hi : lo;

	// moves are held off by the controller for the whole operation
	assert property (@(posedge clk) disable iff (!rstN)
		!(commit && moveWr));

endmodule

`default_nettype wire

//--- hw/hiLoUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hiLoUnit import hiLoPkg::*; (
	input  wire logic      clk,
	input  wire logic      rstN,
	input  wire logic      start,
	input  wire mulDivOp_t op,
	input  wire word_t     a,
	input  wire word_t     b,
	input  wire logic      hiLoWr,
	input  wire hiLoSel_t  hiLoSelWr,
	input  wire hiLoSel_t  hiLoSelRd,
	input  wire logic      flush,
	output logic           busy,
	output word_t          hiLoOut
);

	logic   load;
	logic   step;
	logic   commit;
	logic   resultIsDiv;
	logic   moveWr;
	logic   lastStep;
	dword_t product;
	word_t  quotient;
	word_t  remainder;

	mulDivCtrl u_mulDivCtrl (
		.clk(clk), .rstN(rstN), .start(start), .op(op), .flush(flush),
		.hiLoWr(hiLoWr), .lastStep(lastStep),

		.load(load), .step(step), .commit(commit), .resultIsDiv(resultIsDiv),
		.moveWr(moveWr), .busy(busy)
	);

	stepCounter u_stepCounter (
		.clk(clk), .rstN(rstN), .load(load), .step(step),

		.lastStep(lastStep)
	);

	// both datapaths run every operation, the result mux picks one
	seqMultiplier u_seqMultiplier (
		.clk(clk), .rstN(rstN), .load(load), .step(step), .op(op), .a(a), .b(b),

		.product(product)
	);

	iterDivider u_iterDivider (
		.clk(clk), .rstN(rstN), .load(load), .step(step), .op(op), .a(a), .b(b),

		.quotient(quotient), .remainder(remainder)
	);

	// move data comes straight from the rs operand
	hiLoRegs u_hiLoRegs (
		.clk(clk), .rstN(rstN), .commit(commit), .resultIsDiv(resultIsDiv),
		.product(product), .quotient(quotient), .remainder(remainder),
		.moveWr(moveWr), .hiLoSelWr(hiLoSelWr), .moveData(a), .hiLoSelRd(hiLoSelRd),

		.hiLoOut(hiLoOut)
	);

endmodule

`default_nettype wire

//--- verification/tb_hiLoUnit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_hiLoUnit import hiLoPkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int BUSY_CYCLES = STEP_COUNT + 1;
	localparam int RANDOM_PAIRS = 20;
	localparam int unsigned RANDOM_SEED = 32'h7ac6_5cf3;
	// corners and random pairs for both ops, plus flush, ignored-request and move runs
	localparam int OP_COUNT = 10 + 2 * RANDOM_PAIRS + 8 + 2 * RANDOM_PAIRS + 2 + 1 + 6;
	localparam int CYCLE_LIMIT = 2 * (OP_COUNT * 40 + RESET_CYCLES);

	logic      clk;
	logic      rstN;
	logic      start;
	mulDivOp_t op;
	word_t     a;
	word_t     b;
	logic      hiLoWr;
	hiLoSel_t  hiLoSelWr;
	hiLoSel_t  hiLoSelRd;
	logic      flush;
	logic      busy;
	word_t     hiLoOut;

	int          errors = 0;
	int          checks = 0;
	int          cycleCount = 0;
	int unsigned seedValue;

	hiLoUnit u_hiLoUnit (
		.clk(clk), .rstN(rstN), .start(start), .op(op), .a(a), .b(b),
		.hiLoWr(hiLoWr), .hiLoSelWr(hiLoSelWr), .hiLoSelRd(hiLoSelRd), .flush(flush),
		.busy(busy), .hiLoOut(hiLoOut)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkCycles(input int busyCycles);
		checks++;
		if (busyCycles != BUSY_CYCLES) begin
			errors++;
			$display("ERROR at %0t: busy was high for %0d cycles instead of %0d",
				$time, busyCycles, BUSY_CYCLES);
		end
	endtask

	// both reads land in the low half of the clock
	task automatic readHiLo(output word_t hiVal, output word_t loVal);
		hiLoSelRd = SEL_HI;
		#1;
		hiVal = hiLoOut;
		hiLoSelRd = SEL_LO;
		#1;
		loVal = hiLoOut;
	endtask

	// expected {HI, LO}
	function automatic dword_t modelResult(input mulDivOp_t opIn, input word_t x, input word_t y);
		logic signed [2*WORD_WIDTH-1:0] sx;
		logic signed [2*WORD_WIDTH-1:0] sy;
		dword_t ux;
		dword_t uy;
		sx = $signed(x);
		sy = $signed(y);
		ux = {{WORD_WIDTH{1'b0}}, x};
		uy = {{WORD_WIDTH{1'b0}}, y};
		case (opIn)
			OP_MULT:  return sx * sy;
			OP_MULTU: return ux * uy;
			// truncating quotient, remainder signed like the dividend
			OP_DIV:   return {word_t'(sx % sy), word_t'(sx / sy)};
			default:  return {word_t'(x % y), word_t'(x / y)};
		endcase
	endfunction

	task automatic startOp(input mulDivOp_t opIn, input word_t x, input word_t y);
		@(negedge clk);
		op = opIn;
		a = x;
		b = y;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic waitIdle(output int busyCycles);
		busyCycles = 0;
		while (busy && busyCycles < 2 * BUSY_CYCLES) begin
			busyCycles++;
			@(negedge clk);
		end
		if (busy) begin
			errors++;
			$display("ERROR at %0t: busy never went low after the operation", $time);
		end
	endtask

	task automatic moveTo(input hiLoSel_t sel, input word_t data);
		@(negedge clk);
		hiLoSelWr = sel;
		a = data;
		hiLoWr = 1'b1;
		@(negedge clk);
		hiLoWr = 1'b0;
	endtask

	task automatic runOp(input mulDivOp_t opIn, input word_t x, input word_t y);
		word_t  hiVal;
		word_t  loVal;
		dword_t expected;
		int     busyCycles;
		expected = modelResult(opIn, x, y);
		startOp(opIn, x, y);
		waitIdle(busyCycles);
		checkCycles(busyCycles);
		readHiLo(hiVal, loVal);
		checkWord("HI", expected[2*WORD_WIDTH-1:WORD_WIDTH], hiVal);
		checkWord("LO", expected[WORD_WIDTH-1:0], loVal);
	endtask

	task automatic runSignedAndUnsigned(input logic isDiv, input word_t x, input word_t y);
		runOp(isDiv ? OP_DIV : OP_MULT, x, y);
		runOp(isDiv ? OP_DIVU : OP_MULTU, x, y);
	endtask

	task automatic testResetAndMoves();
		word_t hiVal;
		word_t loVal;
		checks++;
		if (busy !== 1'b0) begin
			errors++;
			$display("CHECK FAILED at %0t: busy expected 0, got %b", $time, busy);
		end
		readHiLo(hiVal, loVal);
		checkWord("HI", '0, hiVal);
		checkWord("LO", '0, loVal);
		moveTo(SEL_HI, 32'hdead_beef);
		readHiLo(hiVal, loVal);
		checkWord("HI", 32'hdead_beef, hiVal);
		checkWord("LO", '0, loVal);
		moveTo(SEL_LO, 32'h0123_4567);
		readHiLo(hiVal, loVal);
		checkWord("HI", 32'hdead_beef, hiVal);
		checkWord("LO", 32'h0123_4567, loVal);
	endtask

	task automatic testMultiply();
		runSignedAndUnsigned(1'b0, -32'sd3, -32'sd7);
		runSignedAndUnsigned(1'b0, 32'h8000_0000, 32'h0000_0003);
		runSignedAndUnsigned(1'b0, 32'h8000_0000, 32'h8000_0000);
		runSignedAndUnsigned(1'b0, 32'h0000_0000, 32'h1234_5678);
		runSignedAndUnsigned(1'b0, 32'hffff_ffff, 32'hffff_ffff);
		for (int i = 0; i < RANDOM_PAIRS; i++) begin
			runSignedAndUnsigned(1'b0, $urandom(), $urandom());
		end
	endtask

	task automatic testDivide();
		word_t y;
		runSignedAndUnsigned(1'b1, -32'sd7, 32'sd2);
		runSignedAndUnsigned(1'b1, 32'sd7, -32'sd2);
		runSignedAndUnsigned(1'b1, -32'sd7, -32'sd2);
		runSignedAndUnsigned(1'b1, 32'h8000_0000, 32'h0000_0002);
		for (int i = 0; i < RANDOM_PAIRS; i++) begin
			y = $urandom();
			if (y == '0) y = 32'h0000_0001;
			runSignedAndUnsigned(1'b1, $urandom(), y);
		end
	endtask

	task automatic testFlush();
		word_t hiVal;
		word_t loVal;
		int    waitCycles;
		// known contents that the cancelled divide must not touch
		moveTo(SEL_HI, 32'hc0de_0011);
		moveTo(SEL_LO, 32'hc0de_0022);
		startOp(OP_DIV, 32'h7654_3210, 32'h0000_0013);
		repeat (9) @(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		waitCycles = 0;
		while (busy && waitCycles < 2) begin
			@(negedge clk);
			waitCycles++;
		end
		if (busy) begin
			errors++;
			$display("ERROR at %0t: busy still high two cycles after flush", $time);
		end
		readHiLo(hiVal, loVal);
		checkWord("HI", 32'hc0de_0011, hiVal);
		checkWord("LO", 32'hc0de_0022, loVal);
		runOp(OP_MULT, 32'hffff_fff0, 32'h0000_0100);
	endtask

	task automatic testIgnoredRequests();
		word_t  hiVal;
		word_t  loVal;
		dword_t expected;
		int     busyCycles;
		expected = modelResult(OP_MULTU, 32'h1357_9bdf, 32'h2468_ace0);
		moveTo(SEL_HI, 32'h5a5a_0001);
		moveTo(SEL_LO, 32'h5a5a_0002);
		startOp(OP_MULTU, 32'h1357_9bdf, 32'h2468_ace0);
		repeat (3) @(negedge clk);
		// second start and a move, both while busy
		op = OP_DIV;
		a = 32'h0bad_f00d;
		b = 32'h0000_0005;
		start = 1'b1;
		hiLoSelWr = SEL_LO;
		hiLoWr = 1'b1;
		@(negedge clk);
		start = 1'b0;
		hiLoWr = 1'b0;
		// a refused move leaves both registers alone until the commit
		readHiLo(hiVal, loVal);
		checkWord("HI", 32'h5a5a_0001, hiVal);
		checkWord("LO", 32'h5a5a_0002, loVal);
		waitIdle(busyCycles);
		checkCycles(busyCycles + 4);
		readHiLo(hiVal, loVal);
		checkWord("HI", expected[2*WORD_WIDTH-1:WORD_WIDTH], hiVal);
		checkWord("LO", expected[WORD_WIDTH-1:0], loVal);
	endtask

	initial begin
		rstN = 1'b0;
		start = 1'b0;
		op = OP_MULT;
		a = '0;
		b = '0;
		hiLoWr = 1'b0;
		hiLoSelWr = SEL_LO;
		hiLoSelRd = SEL_LO;
		flush = 1'b0;
		seedValue = $urandom(RANDOM_SEED);
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;
		testResetAndMoves();
		testMultiply();
		testDivide();
		testFlush();
		testIgnoredRequests();
		$display("Finished: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hiLoUnit.f
hw/hiLoPkg.sv
hw/mulDivCtrl.sv
hw/stepCounter.sv
hw/seqMultiplier.sv
hw/iterDivider.sv
hw/hiLoRegs.sv
hw/hiLoUnit.sv
verification/tb_hiLoUnit.sv
